/* common/mmuTypesPkg.sv */
// Address, page number, VPN slice, PTE word and page type vector types
`include "mmu_defs.svh"

package mmuTypesPkg;

  //////////////////////////////////////////////////////////////////////
  // Word-sized quantities
  //////////////////////////////////////////////////////////////////////

  // satp, PTEs and virtual addresses all share the register width
  typedef logic [`MMU_XLEN-1:0] xlenT;

  //////////////////////////////////////////////////////////////////////
  // Physical side
  //////////////////////////////////////////////////////////////////////

  // Full Sv39 physical address, never truncated on the way out
  typedef logic [`MMU_PA_BITS-1:0] pAddrT;

  // Physical page number as stored in satp and in each PTE
  typedef logic [`MMU_PPN_BITS-1:0] ppnT;

  //////////////////////////////////////////////////////////////////////
  // Virtual side and TLB result
  //////////////////////////////////////////////////////////////////////

  // Index into one 512-entry page table
  typedef logic [`MMU_VPN_BITS-1:0] vpnSliceT;

  // Leaf size written to the TLB
  // 0 is a 4 KiB page, 1 a megapage, 2 a gigapage
  typedef logic [1:0] pageTypeT;

endpackage

/* common/mmu_defs.svh */
// Sv39 walker width macros and PTE flag bit positions
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// Register width, also the width of one page table entry
`define MMU_XLEN 64

// Sv39 physical address and physical page number widths
`define MMU_PA_BITS 56
`define MMU_PPN_BITS 44

// Each level of the walk consumes one 9-bit slice of the VPN
`define MMU_VPN_BITS 9

// PTEs are 8 bytes, so a PTE address ends in three zero bits
`define MMU_PTE_BYTES_LOG2 3

// Low flag byte of a PTE and where the PPN field begins
`define MMU_PTE_FLAG_BITS 8
`define MMU_PTE_PPN_LSB 10

// Flag bit positions inside the low byte
`define MMU_PTE_BIT_V 0
`define MMU_PTE_BIT_R 1
`define MMU_PTE_BIT_W 2
`define MMU_PTE_BIT_X 3
`define MMU_PTE_BIT_A 6
`define MMU_PTE_BIT_D 7

`endif

/* common/pteIf.sv */
// Interface for the current PTE and its decoded checks
`timescale 1ns/1ps

interface pteIf;
  import mmuTypesPkg::*;

  // PTE being looked at this cycle, live on MMUReady, else the held copy
  xlenT currentPte;

  // PPN field of currentPte, the base of the next table or the leaf page
  ppnT  currentPpn;

  // V set and not the reserved writable-but-not-readable encoding
  logic validPte;

  // Any of R, W or X set
  logic leafPte;

  // A clear, or D clear on a store
  logic accessAlert;

  // Superpage alignment checks on the low PPN fields
  logic gigaMisaligned;
  logic megaMisaligned;

  // Driving side, owned by the PTE checker
  modport check (
    output currentPte,
    output currentPpn,
    output validPte,
    output leafPte,
    output accessAlert,
    output gigaMisaligned,
    output megaMisaligned
  );

  // Consuming side, used by the controller and the address generator
  modport user (
    input currentPte,
    input currentPpn,
    input validPte,
    input leafPte,
    input accessAlert,
    input gigaMisaligned,
    input megaMisaligned
  );

endinterface

/* common/walkPkg.sv */
// Walker state enumeration and page table level index type
package walkPkg;

  // Walker FSM states
  // The three level states each wait for one PTE from memory,
  // leaf and fault last one cycle before idle or the next walk
  typedef enum logic [2:0] {
    idle,
    level2,
    level1,
    level0,
    leaf,
    fault
  } walkStateT;

  // Index of the page table level being read
  // Level 2 is the root table, level 0 the last one
  // A leaf found at level N has page type N
  typedef logic [1:0] levelT;

endpackage

/* run.sh */
#!/bin/sh
# Build the page table walker testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tbPageTableWalker -f verilog.f --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/VtbPageTableWalker +verilator+error+limit+100 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* sim/pageTableWalker_props.sv */
// Bound protocol assertions on the page table walker top-level ports
`timescale 1ns/1ps

module pageTableWalkerProps (
  input logic clk,
  input logic rstN,
  input logic ITLBMissF,
  input logic DTLBMissM,
  input logic ITLBWriteF,
  input logic DTLBWriteM,
  input logic MMUTranslate,
  input logic MMUStall,
  input logic WalkerInstrPageFaultF,
  input logic WalkerLoadPageFaultM,
  input logic WalkerStorePageFaultM
);

  // Number of failed assertions, read by the testbench at the end of the run
  int failCount = 0;
  logic anyFault;
  logic anyWrite;

  assign anyFault = WalkerInstrPageFaultF || WalkerLoadPageFaultM || WalkerStorePageFaultM;
  assign anyWrite = ITLBWriteF || DTLBWriteM;

  // One walk serves exactly one TLB
  oneWrite: assert property (@(posedge clk) disable iff (!rstN) !(ITLBWriteF && DTLBWriteM))
    else begin
      failCount++;
      $error("ITLB and DTLB write strobes high together");
    end

  // A walk ends either in a leaf or in a fault, never both
  writeOrFault: assert property (@(posedge clk) disable iff (!rstN) !(anyWrite && anyFault))
    else begin
      failCount++;
      $error("TLB write strobe and page fault high together");
    end

  // With no miss pending the pipeline must run
  noMissNoStall: assert property (@(posedge clk) disable iff (!rstN)
      !(ITLBMissF || DTLBMissM) |-> !MMUStall)
    else begin
      failCount++;
      $error("MMUStall high without a TLB miss");
    end

  // Faults belong to a walk in progress
  faultInWalk: assert property (@(posedge clk) disable iff (!rstN) anyFault |-> MMUTranslate)
    else begin
      failCount++;
      $error("page fault while MMUTranslate is low");
    end

endmodule

bind pageTableWalker pageTableWalkerProps pageTableWalkerProps_i (
  .clk                   (clk),
  .rstN                  (rstN),
  .ITLBMissF             (ITLBMissF),
  .DTLBMissM             (DTLBMissM),
  .ITLBWriteF            (ITLBWriteF),
  .DTLBWriteM            (DTLBWriteM),
  .MMUTranslate          (MMUTranslate),
  .MMUStall              (MMUStall),
  .WalkerInstrPageFaultF (WalkerInstrPageFaultF),
  .WalkerLoadPageFaultM  (WalkerLoadPageFaultM),
  .WalkerStorePageFaultM (WalkerStorePageFaultM)
);

/* sim/tbPageTableWalker.sv */
// Testbench with clock, reset, page table memory model, reference walk and result checks
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tbPageTableWalker;
  import mmuTypesPkg::*;

  localparam int NumWalks    = 19;
  localparam int ResetCycles = 4;
  // Three levels of up to four cycles each fit easily in 40 cycles per walk
  localparam int CycleLimit  = 40 * NumWalks + ResetCycles;

  // The root table sits at satp and leads to one level 1 and two level 0 tables
  localparam ppnT RootPpn    = 44'h80000;
  localparam ppnT Level1Ppn  = 44'h80001;
  localparam ppnT Level0Ppn  = 44'h80002;
  localparam ppnT Level0bPpn = 44'h80003;

  // PTE flag bytes with D A G U X W R V from high to low
  localparam logic [7:0] Pointer    = 8'h01;
  localparam logic [7:0] FullLeaf   = 8'hCF;
  localparam logic [7:0] ExecLeaf   = 8'hCB;
  localparam logic [7:0] NoAccessed = 8'h87;
  localparam logic [7:0] NoDirty    = 8'h47;
  localparam logic [7:0] WriteOnly  = 8'hC5;
  localparam logic [7:0] Invalid    = 8'hCE;

  logic     clk;
  logic     rstN;
  xlenT     SATP_REGW;
  xlenT     PCF;
  xlenT     MemAdrM;
  logic     ITLBMissF;
  logic     DTLBMissM;
  logic     [1:0] MemRWM;
  xlenT     MMUReadPTE;
  logic     MMUReady;
  xlenT     PageTableEntry;
  pageTypeT PageType;
  logic     ITLBWriteF;
  logic     DTLBWriteM;
  pAddrT    MMUPAdr;
  logic     MMUTranslate;
  logic     MMUStall;
  logic     WalkerInstrPageFaultF;
  logic     WalkerLoadPageFaultM;
  logic     WalkerStorePageFaultM;

  // Sparse page table memory where absent entries read as zero
  xlenT ptMem [pAddrT];
  int   errors = 0;
  int   walksDone = 0;
  int   cycleCount = 0;

  pageTableWalker dut_i (.*);

  ////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic xlenT pteOf(input ppnT ppn, input logic [7:0] flags);
    return {10'b0, ppn, 2'b00, flags};
  endfunction

  // Sv39 PTE address with 8 bytes per entry
  function automatic pAddrT pteAddr(input ppnT ppn, input int idx);
    return {ppn, 9'(idx), 3'b000};
  endfunction

  // Virtual address with a fixed page offset and the bits above 38 left at zero
  function automatic xlenT vaOf(input int vpn2, input int vpn1, input int vpn0);
    return {25'b0, 9'(vpn2), 9'(vpn1), 9'(vpn0), 12'h5A8};
  endfunction

  task automatic checkValue(input string what, input xlenT actual, input xlenT expected);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Expected result of one Sv39 walk
  // Kind 0 ITLB write, 1 DTLB write, 2 instruction, 3 load, 4 store fault
  function automatic void refWalk(input xlenT satp, input xlenT va, input logic isData,
                                  input logic isStore, output int kind,
                                  output xlenT leafPte, output pageTypeT leafType);
    ppnT   base;
    xlenT  entry;
    pAddrT adr;
    logic  valid;
    logic  isLeaf;
    logic  alert;
    logic  misaligned;
    int    lvl;
    base     = satp[43:0];
    leafPte  = '0;
    leafType = '0;
    kind     = !isData ? 2 : (isStore ? 4 : 3);
    for (lvl = 2; lvl >= 0; lvl--) begin
      adr    = {base, va[12 + 9 * lvl +: 9], 3'b000};
      entry  = ptMem.exists(adr) ? ptMem[adr] : '0;
      valid  = entry[`MMU_PTE_BIT_V] && !(entry[`MMU_PTE_BIT_W] && !entry[`MMU_PTE_BIT_R]);
      isLeaf = entry[`MMU_PTE_BIT_R] || entry[`MMU_PTE_BIT_W] || entry[`MMU_PTE_BIT_X];
      alert  = !entry[`MMU_PTE_BIT_A] || (isStore && !entry[`MMU_PTE_BIT_D]);
      // Gigapages need PPN[17:0] clear, megapages PPN[8:0]
      if (lvl == 2) misaligned = entry[27:10] != 0;
      else if (lvl == 1) misaligned = entry[18:10] != 0;
      else misaligned = 1'b0;
      if (!valid || (isLeaf && (alert || misaligned)) || (!isLeaf && lvl == 0)) return;
      if (isLeaf) begin
        kind     = isData ? 1 : 0;
        leafPte  = entry;
        leafType = pageTypeT'(lvl);
        return;
      end
      base = entry[53:10];
    end
  endfunction

  task automatic buildTables();
    ptMem[pteAddr(RootPpn, 1)]    = pteOf(Level1Ppn, Pointer);
    ptMem[pteAddr(RootPpn, 2)]    = pteOf(44'h40000, FullLeaf);
    ptMem[pteAddr(RootPpn, 3)]    = pteOf(44'h40001, FullLeaf);
    ptMem[pteAddr(RootPpn, 4)]    = pteOf(44'h40000, Invalid);
    ptMem[pteAddr(RootPpn, 5)]    = pteOf(44'h40000, WriteOnly);
    ptMem[pteAddr(Level1Ppn, 0)]  = pteOf(Level0Ppn, Pointer);
    ptMem[pteAddr(Level1Ppn, 1)]  = pteOf(44'h12200, FullLeaf);
    ptMem[pteAddr(Level1Ppn, 2)]  = pteOf(44'h12201, FullLeaf);
    ptMem[pteAddr(Level1Ppn, 3)]  = pteOf(Level0bPpn, Pointer);
    ptMem[pteAddr(Level0Ppn, 0)]  = pteOf(44'h12345, FullLeaf);
    ptMem[pteAddr(Level0Ppn, 1)]  = pteOf(44'h23456, ExecLeaf);
    ptMem[pteAddr(Level0Ppn, 2)]  = pteOf(44'h34567, NoAccessed);
    ptMem[pteAddr(Level0Ppn, 3)]  = pteOf(44'h45678, NoDirty);
    ptMem[pteAddr(Level0Ppn, 4)]  = pteOf(Level1Ppn, Pointer);
    ptMem[pteAddr(Level0Ppn, 5)]  = pteOf(44'h56789, Invalid);
    ptMem[pteAddr(Level0bPpn, 7)] = pteOf(44'h55555, FullLeaf);
  endtask

  // Raises the misses, checks the start of the walk and waits for the results
  task automatic runWalk(input logic iMiss, input logic dMiss, input xlenT pc,
                         input xlenT dataAdr, input logic store);
    int   target;
    xlenT firstVa;
    target  = walksDone + int'(iMiss) + int'(dMiss);
    firstVa = dMiss ? dataAdr : pc;
    @(negedge clk);
    PCF       = pc;
    MemAdrM   = dataAdr;
    MemRWM    = !dMiss ? 2'b00 : (store ? 2'b01 : 2'b10);
    ITLBMissF = iMiss;
    DTLBMissM = dMiss;
    @(posedge clk);
    checkValue("MMUTranslate at walk start", 64'(MMUTranslate), 64'(1));
    checkValue("MMUStall at walk start", 64'(MMUStall), 64'(1));
    checkValue("root PTE address", 64'(MMUPAdr), 64'(pteAddr(RootPpn, int'(firstVa[38:30]))));
    wait (walksDone == target);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Clock, memory model and watchdog
  ////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  initial begin : watchdog
    wait (cycleCount >= CycleLimit);
    $display("Timeout after %0d cycles, a walk never finished", cycleCount);
    $display("test failed");
    $finish;
  end

  // Takes the address of each level request and answers after 0 to 3 cycles
  initial begin : memoryModel
    logic [31:0] rngState;
    logic        pending;
    int          delayLeft;
    pAddrT       reqAdr;
    rngState   = 32'h53650326;
    pending    = 1'b0;
    delayLeft  = 0;
    reqAdr     = '0;
    MMUReady   = 1'b0;
    MMUReadPTE = '0;
    forever begin
      @(posedge clk);
      if (!pending && !MMUReady && MMUTranslate && MMUStall) begin
        pending   = 1'b1;
        reqAdr    = MMUPAdr;
        rngState  = xorshift(rngState);
        delayLeft = int'(rngState[1:0]);
      end
      @(negedge clk);
      MMUReady = 1'b0;
      if (pending && delayLeft == 0) begin
        MMUReady   = 1'b1;
        MMUReadPTE = ptMem.exists(reqAdr) ? ptMem[reqAdr] : '0;
        pending    = 1'b0;
      end else if (pending) begin
        delayLeft--;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Result comparison
  ////////////////////////////////////////////////////////////////////////

  // The side that missed is read from the testbench's own miss inputs
  initial begin : compareResults
    int         expKind;
    xlenT       expPte;
    pageTypeT   expType;
    logic       isData;
    logic [4:0] strobes;
    forever begin
      @(posedge clk);
      strobes = {WalkerStorePageFaultM, WalkerLoadPageFaultM, WalkerInstrPageFaultF,
                 DTLBWriteM, ITLBWriteF};
      if (rstN && strobes != 5'b0) begin
        isData = DTLBMissM;
        refWalk(SATP_REGW, isData ? MemAdrM : PCF, isData, isData && MemRWM[0],
                expKind, expPte, expType);
        checkValue("write and fault strobes", 64'(strobes), 64'(1 << expKind));
        // A leaf keeps the pipeline stalled while a fault releases it
        checkValue("MMUStall at walk end", 64'(MMUStall), 64'(expKind < 2));
        if (expKind < 2) begin
          checkValue("PageTableEntry", PageTableEntry, expPte);
          checkValue("PageType", 64'(PageType), 64'(expType));
        end
        @(negedge clk);
        if (isData) begin
          DTLBMissM = 1'b0;
          MemRWM    = 2'b00;
        end else begin
          ITLBMissF = 1'b0;
        end
        walksDone++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    rstN      = 1'b0;
    SATP_REGW = 64'(RootPpn);
    PCF       = '0;
    MemAdrM   = '0;
    ITLBMissF = 1'b0;
    DTLBMissM = 1'b0;
    MemRWM    = 2'b00;
    buildTables();
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    @(posedge clk);
    checkValue("stall, translate, writes and faults after reset",
               64'({MMUStall, MMUTranslate, ITLBWriteF, DTLBWriteM, WalkerInstrPageFaultF,
                    WalkerLoadPageFaultM, WalkerStorePageFaultM}), '0);
    checkValue("MMUPAdr after reset", 64'(MMUPAdr), '0);

    // 4 KiB pages through all three levels
    runWalk(1'b1, 1'b0, vaOf(1, 0, 0), '0, 1'b0);
    runWalk(1'b0, 1'b1, '0, vaOf(1, 0, 0), 1'b0);
    runWalk(1'b0, 1'b1, '0, vaOf(1, 0, 0), 1'b1);
    runWalk(1'b1, 1'b0, vaOf(1, 0, 1), '0, 1'b0);
    // Megapage and gigapage leaves that are aligned and then misaligned
    runWalk(1'b0, 1'b1, '0, vaOf(1, 1, 77), 1'b0);
    runWalk(1'b1, 1'b0, vaOf(2, 300, 5), '0, 1'b0);
    runWalk(1'b0, 1'b1, '0, vaOf(1, 2, 0), 1'b0);
    runWalk(1'b1, 1'b0, vaOf(3, 0, 0), '0, 1'b0);
    runWalk(1'b0, 1'b1, '0, vaOf(3, 8, 9), 1'b1);
    // Invalid entry, W without R, pointer and invalid entry at level 0
    runWalk(1'b1, 1'b0, vaOf(4, 0, 0), '0, 1'b0);
    runWalk(1'b0, 1'b1, '0, vaOf(5, 0, 0), 1'b0);
    runWalk(1'b0, 1'b1, '0, vaOf(5, 0, 0), 1'b1);
    runWalk(1'b0, 1'b1, '0, vaOf(1, 0, 4), 1'b0);
    runWalk(1'b1, 1'b0, vaOf(1, 0, 5), '0, 1'b0);
    // A clear always faults and D clear faults a store but not a load
    runWalk(1'b0, 1'b1, '0, vaOf(1, 0, 2), 1'b0);
    runWalk(1'b0, 1'b1, '0, vaOf(1, 0, 3), 1'b1);
    runWalk(1'b0, 1'b1, '0, vaOf(1, 0, 3), 1'b0);
    // With both misses at once the data side must be served first
    runWalk(1'b1, 1'b1, vaOf(1, 3, 7), vaOf(1, 1, 12), 1'b0);

    repeat (2) @(negedge clk);
    $display("Walks checked: %0d, errors: %0d, assertion failures: %0d",
             walksDone, errors, dut_i.pageTableWalkerProps_i.failCount);
    if (errors == 0 && dut_i.pageTableWalkerProps_i.failCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* src/pageTableWalker.sv */
// Sv39 page table walker top level with miss arbitration and walker instances
`timescale 1ns/1ps

module pageTableWalker (
  input  logic                  clk,
  input  logic                  rstN,
  input  mmuTypesPkg::xlenT     SATP_REGW,
  input  mmuTypesPkg::xlenT     PCF,
  input  mmuTypesPkg::xlenT     MemAdrM,
  input  logic                  ITLBMissF,
  input  logic                  DTLBMissM,
  input  logic [1:0]            MemRWM,
  input  mmuTypesPkg::xlenT     MMUReadPTE,
  input  logic                  MMUReady,
  output mmuTypesPkg::xlenT     PageTableEntry,
  output mmuTypesPkg::pageTypeT PageType,
  output logic                  ITLBWriteF,
  output logic                  DTLBWriteM,
  output mmuTypesPkg::pAddrT    MMUPAdr,
  output logic                  MMUTranslate,
  output logic                  MMUStall,
  output logic                  WalkerInstrPageFaultF,
  output logic                  WalkerLoadPageFaultM,
  output logic                  WalkerStorePageFaultM
);
  import mmuTypesPkg::*;
  import walkPkg::*;

  xlenT      translationVAdr;
  logic      translate;
  logic      dataWalk;
  logic      memStore;
  walkStateT state;
  walkStateT nextState;

  pteIf pte ();

  //////////////////////////////////////////////////////////////////////
  // Miss arbitration
  //////////////////////////////////////////////////////////////////////

  // A data miss blocks the memory stage, so it is served first
  assign dataWalk        = DTLBMissM;
  assign translate       = DTLBMissM || ITLBMissF;
  assign translationVAdr = dataWalk ? MemAdrM : PCF;
  // Bit 0 of MemRWM marks a store
  assign memStore        = MemRWM[0];
  assign MMUTranslate    = translate;

  //////////////////////////////////////////////////////////////////////
  // Walker blocks
  //////////////////////////////////////////////////////////////////////

  pteCheck pteCheck_i (
    .clk        (clk),
    .rstN       (rstN),
    .MMUReady   (MMUReady),
    .MMUReadPTE (MMUReadPTE),
    .memStore   (memStore),
    .pte        (pte.check)
  );

  walkControl walkControl_i (
    .clk                   (clk),
    .rstN                  (rstN),
    .translate             (translate),
    .dataWalk              (dataWalk),
    .memStore              (memStore),
    .MMUReady              (MMUReady),
    .pte                   (pte.user),
    .state                 (state),
    .nextState             (nextState),
    .PageTableEntry        (PageTableEntry),
    .PageType              (PageType),
    .ITLBWriteF            (ITLBWriteF),
    .DTLBWriteM            (DTLBWriteM),
    .MMUStall              (MMUStall),
    .WalkerInstrPageFaultF (WalkerInstrPageFaultF),
    .WalkerLoadPageFaultM  (WalkerLoadPageFaultM),
    .WalkerStorePageFaultM (WalkerStorePageFaultM)
  );

  ptAddressGen ptAddressGen_i (
    .SATP_REGW       (SATP_REGW),
    .translationVAdr (translationVAdr),
    .state           (state),
    .nextState       (nextState),
    .pte             (pte.user),
    .MMUPAdr         (MMUPAdr)
  );

endmodule

/* verilog.f */
+incdir+common
common/mmuTypesPkg.sv
common/walkPkg.sv
common/pteIf.sv
walker/pteCheck.sv
walker/walkControl.sv
walker/ptAddressGen.sv
src/pageTableWalker.sv
sim/pageTableWalker_props.sv
sim/tbPageTableWalker.sv

/* walker/ptAddressGen.sv */
// PTE physical address formation from satp or the current PPN and a VPN slice
`timescale 1ns/1ps
`include "mmu_defs.svh"

module ptAddressGen (
  input  mmuTypesPkg::xlenT  SATP_REGW,
  input  mmuTypesPkg::xlenT  translationVAdr,
  input  walkPkg::walkStateT state,
  input  walkPkg::walkStateT nextState,
  pteIf.user                 pte,
  output mmuTypesPkg::pAddrT MMUPAdr
);
  import mmuTypesPkg::*;
  import walkPkg::*;

  // The 4 KiB page offset below VPN0
  localparam int PageOffsetBits = `MMU_VPN_BITS + `MMU_PTE_BYTES_LOG2;
  localparam logic [`MMU_PTE_BYTES_LOG2-1:0] PteOffset = '0;

  ppnT      rootPpn;
  ppnT      heldPpn;
  vpnSliceT vpn2;
  vpnSliceT vpn1;
  vpnSliceT vpn0;
  vpnSliceT heldVpn;

  // Only the PPN field of satp matters, the mode is fixed at Sv39
  assign rootPpn = SATP_REGW[`MMU_PPN_BITS-1:0];

  assign vpn0 = translationVAdr[PageOffsetBits +: `MMU_VPN_BITS];
  assign vpn1 = translationVAdr[PageOffsetBits + `MMU_VPN_BITS +: `MMU_VPN_BITS];
  assign vpn2 = translationVAdr[PageOffsetBits + 2 * `MMU_VPN_BITS +: `MMU_VPN_BITS];

  // Base and slice of the level just read, used when the walk finishes
  always_comb begin
    case (state)
      level2: begin
        heldPpn = rootPpn;
        heldVpn = vpn2;
      end
      level1: begin
        heldPpn = pte.currentPpn;
        heldVpn = vpn1;
      end
      default: begin
        heldPpn = pte.currentPpn;
        heldVpn = vpn0;
      end
    endcase
  end

  // Address follows the next state so the bus sees it in the same cycle
  always_comb begin
    case (nextState)
      level2:        MMUPAdr = {rootPpn, vpn2, PteOffset};
      level1:        MMUPAdr = {pte.currentPpn, vpn1, PteOffset};
      level0:        MMUPAdr = {pte.currentPpn, vpn0, PteOffset};
      // Keep a nonzero address on the bus while the result is handed over
      leaf, fault:   MMUPAdr = {heldPpn, heldVpn, PteOffset};
      default:       MMUPAdr = '0;
    endcase
  end

endmodule

/* walker/pteCheck.sv */
// PTE holding register, live or held PTE select and PTE descriptor decode
`timescale 1ns/1ps
`include "mmu_defs.svh"

module pteCheck (
  input  logic              clk,
  input  logic              rstN,
  input  logic              MMUReady,
  input  mmuTypesPkg::xlenT MMUReadPTE,
  input  logic              memStore,
  pteIf.check               pte
);
  import mmuTypesPkg::*;

  // Two alignment masks, one VPN slice for megapages and two for gigapages
  localparam int MegaBits = `MMU_VPN_BITS;
  localparam int GigaBits = 2 * `MMU_VPN_BITS;

  xlenT savedPte;
  xlenT currentPte;
  ppnT  currentPpn;
  logic [`MMU_PTE_FLAG_BITS-1:0] pteFlags;
  logic flagV;
  logic flagR;
  logic flagW;
  logic flagX;
  logic flagA;
  logic flagD;

  //////////////////////////////////////////////////////////////////////
  // PTE capture
  //////////////////////////////////////////////////////////////////////

  // Memory gives the PTE for a single cycle, keep it for the wait states
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      savedPte <= '0;
    end else if (MMUReady) begin
      savedPte <= MMUReadPTE;
    end
  end

  // Decisions are made in the MMUReady cycle itself, so bypass the register
  assign currentPte = MMUReady ? MMUReadPTE : savedPte;
  assign currentPpn = currentPte[`MMU_PTE_PPN_LSB +: `MMU_PPN_BITS];

  //////////////////////////////////////////////////////////////////////
  // Flag decode
  //////////////////////////////////////////////////////////////////////

  assign pteFlags = currentPte[`MMU_PTE_FLAG_BITS-1:0];
  assign flagV    = pteFlags[`MMU_PTE_BIT_V];
  assign flagR    = pteFlags[`MMU_PTE_BIT_R];
  assign flagW    = pteFlags[`MMU_PTE_BIT_W];
  assign flagX    = pteFlags[`MMU_PTE_BIT_X];
  assign flagA    = pteFlags[`MMU_PTE_BIT_A];
  assign flagD    = pteFlags[`MMU_PTE_BIT_D];

  // W without R is reserved and counts as invalid
  assign pte.validPte    = flagV && !(flagW && !flagR);
  // A pointer to the next table has R, W and X all clear
  assign pte.leafPte     = flagR || flagW || flagX;
  // No hardware A/D update here, so a missing bit traps to software
  assign pte.accessAlert = !flagA || (memStore && !flagD);

  // Superpages need the PPN bits below their size to be zero
  assign pte.gigaMisaligned = |currentPpn[GigaBits-1:0];
  assign pte.megaMisaligned = |currentPpn[MegaBits-1:0];

  assign pte.currentPte = currentPte;
  assign pte.currentPpn = currentPpn;

endmodule

/* walker/walkControl.sv */
// Walker FSM with its TLB write, page type, stall and fault outputs
`timescale 1ns/1ps

module walkControl (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     translate,
  input  logic                     dataWalk,
  input  logic                     memStore,
  input  logic                     MMUReady,
  pteIf.user                       pte,
  output walkPkg::walkStateT       state,
  output walkPkg::walkStateT       nextState,
  output mmuTypesPkg::xlenT        PageTableEntry,
  output mmuTypesPkg::pageTypeT    PageType,
  output logic                     ITLBWriteF,
  output logic                     DTLBWriteM,
  output logic                     MMUStall,
  output logic                     WalkerInstrPageFaultF,
  output logic                     WalkerLoadPageFaultM,
  output logic                     WalkerStorePageFaultM
);
  import walkPkg::*;
  import mmuTypesPkg::*;

  levelT readLevel;
  logic  goodGigapage;
  logic  goodMegapage;
  logic  goodPage;
  logic  descend;

  //////////////////////////////////////////////////////////////////////
  // PTE verdicts
  //////////////////////////////////////////////////////////////////////

  // A usable leaf at each level, superpages also need their alignment
  assign goodPage     = pte.validPte && pte.leafPte && !pte.accessAlert;
  assign goodGigapage = goodPage && !pte.gigaMisaligned;
  assign goodMegapage = goodPage && !pte.megaMisaligned;

  // Valid pointer to a lower table
  assign descend = pte.validPte && !pte.leafPte;

  //////////////////////////////////////////////////////////////////////
  // State register and next-state rules
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (translate) nextState = level2;
      end
      level2: begin
        // Each level waits here until memory returns the PTE
        if (MMUReady) begin
          if (goodGigapage) nextState = leaf;
          else if (descend) nextState = level1;
          else nextState = fault;
        end
      end
      level1: begin
        if (MMUReady) begin
          if (goodMegapage) nextState = leaf;
          else if (descend) nextState = level0;
          else nextState = fault;
        end
      end
      level0: begin
        // No lower table exists, so a pointer here is a fault too
        if (MMUReady) begin
          if (goodPage) nextState = leaf;
          else nextState = fault;
        end
      end
      leaf, fault: begin
        // Go straight into the next walk if another miss is waiting
        nextState = translate ? level2 : idle;
      end
      default: nextState = idle;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Output decode from the next state
  //////////////////////////////////////////////////////////////////////

  // Level whose PTE is being decided, it sets the page size of a leaf
  always_comb begin
    case (state)
      level2:  readLevel = 2'd2;
      level1:  readLevel = 2'd1;
      default: readLevel = 2'd0;
    endcase
  end

  always_comb begin
    PageTableEntry        = '0;
    PageType              = '0;
    ITLBWriteF            = 1'b0;
    DTLBWriteM            = 1'b0;
    WalkerInstrPageFaultF = 1'b0;
    WalkerLoadPageFaultM  = 1'b0;
    WalkerStorePageFaultM = 1'b0;
    // The processor stays stalled for the whole walk by default
    MMUStall              = 1'b1;
    case (nextState)
      idle: begin
        MMUStall = 1'b0;
      end
      leaf: begin
        PageTableEntry = pte.currentPte;
        PageType       = pageTypeT'(readLevel);
        // Data misses win arbitration, so dataWalk names the missing TLB
        DTLBWriteM     = dataWalk;
        ITLBWriteF     = !dataWalk;
      end
      fault: begin
        WalkerInstrPageFaultF = !dataWalk;
        WalkerLoadPageFaultM  = dataWalk && !memStore;
        WalkerStorePageFaultM = dataWalk && memStore;
        // Release the pipeline early so it can take the trap
        MMUStall              = 1'b0;
      end
      default: begin
      end
    endcase
  end

endmodule
